//--- rtl/dcache_pkg.sv
// dcache package: L1 data cache geometry, MOESI state codes and snoop request types
`default_nettype none

package dcache_pkg;

	// address split is tag | index | byte offset
	localparam int addr_w     = 32;
	localparam int word_w     = 32;
	localparam int word_bytes = word_w / 8;
	localparam int line_off_w = 4;
	localparam int line_bytes = 1 << line_off_w;
	localparam int line_w     = line_bytes * 8;

	localparam int index_w  = 3;
	localparam int nentries = 1 << index_w;
	localparam int tag_w    = addr_w - index_w - line_off_w;

	// four ways, victim pointer wraps on its own
	localparam int nways = 4;
	localparam int way_w = $clog2(nways);

	// MOESI coding
	//   bit 2 set only for M (dirty, exclusive)
	//   bit 0 set for S and O, the lines that another cache may also hold
	localparam int moesi_w = 3;

	localparam logic [moesi_w-1:0] c_i = 3'd0;
	localparam logic [moesi_w-1:0] c_s = 3'd1;
	localparam logic [moesi_w-1:0] c_e = 3'd2;
	localparam logic [moesi_w-1:0] c_o = 3'd3;
	localparam logic [moesi_w-1:0] c_m = 3'd4;

	// snoop request types from the coherent interconnect
	localparam logic [1:0] snoop_read_unshared  = 2'd0;	// peek only, state kept
	localparam logic [1:0] snoop_read_shared    = 2'd1;	// requester wants a shared copy
	localparam logic [1:0] snoop_read_exclusive = 2'd2;	// requester takes ownership
	localparam logic [1:0] snoop_read_invalid   = 2'd3;	// drop the line, no data

endpackage

`default_nettype wire

//--- rtl/load_select.sv
// load_select: one-hot way select of the read line and word pick for the load port
`timescale 1ns/1ps
`default_nettype none

module load_select (
	input  logic [dcache_pkg::addr_w-1:0]                    load_addr,
	input  logic [dcache_pkg::nways-1:0]                     load_match_vec,
	input  logic [dcache_pkg::nways-1:0]                     load_need_vec,
	input  logic [dcache_pkg::nways-1:0][dcache_pkg::line_w-1:0] load_line_vec,
	output logic                                             load_hit,
	output logic                                             load_need_o,
	output logic [dcache_pkg::word_w-1:0]                    load_data
);
	import dcache_pkg::*;

	logic [line_w-1:0]                        line_sel;
	logic [line_off_w-$clog2(word_bytes)-1:0] word_idx;

	assign load_hit    = |load_match_vec;
	assign load_need_o = |(load_match_vec & load_need_vec);
	assign word_idx    = load_addr[line_off_w-1:$clog2(word_bytes)];

	always_comb begin
		line_sel = '0;
		for (int w = 0; w < nways; w++) begin
			if (load_match_vec[w])
				line_sel |= load_line_vec[w];
		end
	end

	assign load_data = line_sel[word_idx*word_w +: word_w];	// zero on a miss

endmodule

`default_nettype wire

//--- rtl/dcache_way.sv
// dcache_way: tag, MOESI state and data arrays of one cache way with their four lookups
`timescale 1ns/1ps
`default_nettype none

module dcache_way (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [dcache_pkg::addr_w-1:0]     load_addr,
	input  logic                              store_en,
	input  logic [dcache_pkg::addr_w-1:0]     store_addr,
	input  logic [dcache_pkg::word_w-1:0]     store_data,
	input  logic [dcache_pkg::word_bytes-1:0] store_mask,
	input  logic [dcache_pkg::addr_w-1:0]     fill_addr,
	input  logic [dcache_pkg::line_w-1:0]     fill_data,
	input  logic                              fill_write,
	input  logic [dcache_pkg::moesi_w-1:0]    fill_state,
	input  logic [dcache_pkg::addr_w-1:0]     snoop_addr,
	input  logic                              snoop_write,
	input  logic [dcache_pkg::moesi_w-1:0]    snoop_state,
	output logic                              load_match,
	output logic                              load_need_o,
	output logic [dcache_pkg::line_w-1:0]     load_line,
	output logic                              store_hit_ok,
	output logic                              store_hit_inval,
	output logic                              store_writing,
	output logic                              fill_match,
	output logic [dcache_pkg::moesi_w-1:0]    fill_state_now,
	output logic [dcache_pkg::tag_w-1:0]      fill_tag_now,
	output logic [dcache_pkg::line_w-1:0]     fill_line_now,
	output logic                              snoop_match,
	output logic [dcache_pkg::moesi_w-1:0]    snoop_state_now,
	output logic [dcache_pkg::line_w-1:0]     snoop_line
);
	import dcache_pkg::*;

	logic [tag_w-1:0]   tag_q   [nentries];
	logic [moesi_w-1:0] state_q [nentries];
	logic [line_w-1:0]  data_q  [nentries];

	logic [index_w-1:0]    load_idx, store_idx, fill_idx, snoop_idx;
	logic [moesi_w-1:0]    load_state, store_state;
	logic                  store_tag_eq, store_wr;
	logic [line_bytes-1:0] store_bmask;
	logic [line_w-1:0]     store_rep, store_merged;

	assign load_idx  = load_addr[line_off_w +: index_w];
	assign store_idx = store_addr[line_off_w +: index_w];
	assign fill_idx  = fill_addr[line_off_w +: index_w];
	assign snoop_idx = snoop_addr[line_off_w +: index_w];

	assign load_state  = state_q[load_idx];
	assign load_match  = load_state != c_i && tag_q[load_idx] == load_addr[addr_w-1 -: tag_w];
	assign load_need_o = load_state[0];	// S or O, needs ownership first
	assign load_line   = data_q[load_idx];

	assign store_state     = state_q[store_idx];
	assign store_tag_eq    = tag_q[store_idx] == store_addr[addr_w-1 -: tag_w];
	assign store_hit_ok    = (store_state == c_e || store_state == c_m) && store_tag_eq;
	assign store_hit_inval = store_state[0] && store_tag_eq;
	assign store_writing   = store_en && store_hit_ok;
	assign store_wr        = store_writing && !fill_write;	// fill wins the way

	assign fill_state_now = state_q[fill_idx];
	assign fill_tag_now   = tag_q[fill_idx];
	assign fill_line_now  = data_q[fill_idx];
	assign fill_match     = fill_state_now != c_i && fill_tag_now == fill_addr[addr_w-1 -: tag_w];

	assign snoop_state_now = state_q[snoop_idx];
	assign snoop_line      = data_q[snoop_idx];
	assign snoop_match     = snoop_state_now != c_i &&
		tag_q[snoop_idx] == snoop_addr[addr_w-1 -: tag_w];

	// byte enables placed at the word position within the line
	assign store_bmask = line_bytes'(store_mask) <<
		(store_addr[line_off_w-1:$clog2(word_bytes)] * word_bytes);
	assign store_rep = {(line_w / word_w){store_data}};

	always_comb begin
		store_merged = data_q[store_idx];
		for (int b = 0; b < line_bytes; b++) begin
			if (store_bmask[b])
				store_merged[b*8 +: 8] = store_rep[b*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (fill_write) begin
			tag_q[fill_idx]  <= fill_addr[addr_w-1 -: tag_w];
			data_q[fill_idx] <= fill_data;
		end else if (store_wr) begin
			data_q[store_idx] <= store_merged;
		end
	end

	// later writes win when indices collide: fill, then snoop, then store
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < nentries; i++)
				state_q[i] <= c_i;
		end else begin
			if (store_wr && store_state == c_e)
				state_q[store_idx] <= c_m;	// first store dirties the line
			if (snoop_write)
				state_q[snoop_idx] <= snoop_state;
			if (fill_write)
				state_q[fill_idx] <= fill_state;
		end
	end

	// allocation never picks the way being stored to, only a refresh can collide
	a_fill_store: assert property (@(posedge clk) disable iff (reset)
		fill_write && store_writing |-> fill_match);

endmodule

`default_nettype wire

//--- rtl/fill_evict_ctrl.sv
// fill_evict_ctrl: line fill placement, rotating victim choice and registered writeback port
`timescale 1ns/1ps
`default_nettype none

module fill_evict_ctrl (
	input  logic                                              clk,
	input  logic                                              reset,
	input  logic                                              fill_req,
	input  logic [dcache_pkg::addr_w-1:0]                     fill_addr,
	input  logic [2:0]                                        fill_resp,
	input  logic [dcache_pkg::nways-1:0]                      fill_match_vec,
	input  logic [dcache_pkg::nways-1:0][dcache_pkg::moesi_w-1:0] fill_state_vec,
	input  logic [dcache_pkg::nways-1:0][dcache_pkg::tag_w-1:0]   fill_tag_vec,
	input  logic [dcache_pkg::nways-1:0][dcache_pkg::line_w-1:0]  fill_line_vec,
	input  logic [dcache_pkg::nways-1:0]                      store_writing_vec,
	input  logic                                              wb_ack,
	output logic                                              fill_ack,
	output logic [dcache_pkg::nways-1:0]                      fill_write_vec,
	output logic [dcache_pkg::moesi_w-1:0]                    fill_state,
	output logic                                              wb_req,
	output logic [dcache_pkg::addr_w-1:0]                     wb_addr,
	output logic [dcache_pkg::line_w-1:0]                     wb_data
);
	import dcache_pkg::*;

	logic [way_w-1:0]   victim_ptr, victim;
	logic [nways-1:0]   free_vec, first_free, victim_oh, place;
	logic [index_w-1:0] fill_idx;
	logic               victim_dirty, wb_busy, evict, xfer;

	always_comb begin
		casez (fill_resp)
			3'b1??:  fill_state = c_m;
			3'b01?:  fill_state = c_e;
			default: fill_state = c_s;
		endcase
	end

	assign fill_idx = fill_addr[line_off_w +: index_w];

	always_comb begin
		for (int w = 0; w < nways; w++)
			free_vec[w] = fill_state_vec[w] == c_i && !store_writing_vec[w];
	end
	assign first_free = free_vec & (~free_vec + 1'b1);	// lowest vacant way

	// step past the way the store port is writing
	assign victim       = store_writing_vec[victim_ptr] ? victim_ptr + 1'b1 : victim_ptr;
	assign victim_oh    = nways'(1) << victim;
	assign victim_dirty = fill_state_vec[victim] == c_m || fill_state_vec[victim] == c_o;
	assign wb_busy      = wb_req && !wb_ack;

	always_comb begin
		place    = '0;
		evict    = 1'b0;
		fill_ack = 1'b1;
		if (|fill_match_vec) begin
			place = fill_match_vec;	// refresh in place
		end else if (fill_resp[0]) begin
			if (|free_vec) begin
				place = first_free;
			end else begin
				place    = victim_oh;
				evict    = 1'b1;
				fill_ack = !(victim_dirty && wb_busy);	// wb register still full
			end
		end
	end

	assign xfer           = fill_req && fill_ack;
	assign fill_write_vec = xfer ? place : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			victim_ptr <= '0;
			wb_req     <= 1'b0;
		end else begin
			if (xfer && evict)
				victim_ptr <= victim_ptr + 1'b1;
			if (xfer && evict && victim_dirty)
				wb_req <= 1'b1;
			else if (wb_ack)
				wb_req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (xfer && evict && victim_dirty) begin
			wb_addr <= {fill_tag_vec[victim], fill_idx, {line_off_w{1'b0}}};
			wb_data <= fill_line_vec[victim];
		end
	end

	a_fill_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(fill_write_vec));

	a_wb_hold: assert property (@(posedge clk) disable iff (reset)
		wb_req && !wb_ack |=> wb_req && $stable(wb_addr) && $stable(wb_data));

endmodule

`default_nettype wire

//--- rtl/snoop_resp.sv
// snoop_resp: snoop hit combine across ways, next MOESI state and registered response
`timescale 1ns/1ps
`default_nettype none

module snoop_resp (
	input  logic                                              clk,
	input  logic                                              reset,
	input  logic                                              snoop_req,
	input  logic [1:0]                                        snoop_type,
	input  logic [dcache_pkg::nways-1:0]                      snoop_match_vec,
	input  logic [dcache_pkg::nways-1:0][dcache_pkg::moesi_w-1:0] snoop_state_vec,
	input  logic [dcache_pkg::nways-1:0][dcache_pkg::line_w-1:0]  snoop_line_vec,
	output logic [dcache_pkg::nways-1:0]                      snoop_write_vec,
	output logic [dcache_pkg::moesi_w-1:0]                    snoop_state,
	output logic [2:0]                                        snoop_resp,
	output logic [dcache_pkg::line_w-1:0]                     snoop_data
);
	import dcache_pkg::*;

	logic [moesi_w-1:0] state_sel;
	logic [line_w-1:0]  line_sel;
	logic               hit, dirty, owned, excl, want_excl;

	always_comb begin
		state_sel = '0;
		line_sel  = '0;
		for (int w = 0; w < nways; w++) begin
			if (snoop_match_vec[w]) begin
				state_sel |= snoop_state_vec[w];
				line_sel  |= snoop_line_vec[w];
			end
		end
	end

	assign hit       = snoop_req && |snoop_match_vec;
	assign dirty     = state_sel[2];
	assign owned     = state_sel == c_o;
	assign excl      = state_sel == c_e || dirty;
	assign want_excl = snoop_type == snoop_read_exclusive;

	always_comb begin
		case (snoop_type)
			snoop_read_shared: snoop_state = (dirty || owned) ? c_o : c_s;
			snoop_read_exclusive,
			snoop_read_invalid: snoop_state = c_i;
			default:            snoop_state = state_sel;	// unshared, no write
		endcase
	end

	assign snoop_write_vec = (snoop_req && snoop_type != snoop_read_unshared) ?
		snoop_match_vec : '0;

	always_ff @(posedge clk) begin
		if (reset)
			snoop_resp <= 3'b000;
		else if (snoop_req)
			snoop_resp <= hit ? {dirty && want_excl, excl && want_excl,
				snoop_type != snoop_read_invalid} : 3'b000;
	end

	always_ff @(posedge clk) begin
		if (snoop_req)
			snoop_data <= (hit && snoop_type != snoop_read_invalid) ? line_sel : '0;
	end

	// a line lives in at most one way
	a_snoop_onehot: assert property (@(posedge clk) disable iff (reset)
		snoop_req |-> $onehot0(snoop_match_vec));

endmodule

`default_nettype wire

//--- rtl/dcache_l1.sv
// dcache_l1: 4-way write-back L1 data cache with MOESI states, load, store, fill, wb, snoop
`timescale 1ns/1ps
`default_nettype none

module dcache_l1 (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [dcache_pkg::addr_w-1:0]  load_addr,
	output logic                           load_hit,
	output logic                           load_need_o,
	output logic [dcache_pkg::word_w-1:0]  load_data,
	input  logic                           store_en,
	input  logic [dcache_pkg::addr_w-1:0]  store_addr,
	input  logic [dcache_pkg::word_w-1:0]  store_data,
	input  logic [dcache_pkg::word_bytes-1:0] store_mask,
	output logic                           store_ok_write,
	output logic                           store_must_invalidate,
	output logic                           store_wait,
	input  logic                           fill_req,
	output logic                           fill_ack,
	input  logic [dcache_pkg::addr_w-1:0]  fill_addr,
	input  logic [dcache_pkg::line_w-1:0]  fill_data,
	input  logic [2:0]                     fill_resp,
	output logic                           wb_req,
	input  logic                           wb_ack,
	output logic [dcache_pkg::addr_w-1:0]  wb_addr,
	output logic [dcache_pkg::line_w-1:0]  wb_data,
	input  logic                           snoop_req,
	input  logic [dcache_pkg::addr_w-1:0]  snoop_addr,
	input  logic [1:0]                     snoop_type,
	output logic [2:0]                     snoop_resp,
	output logic [dcache_pkg::line_w-1:0]  snoop_data
);
	import dcache_pkg::*;

	logic [nways-1:0]                load_match_vec, load_need_vec;
	logic [nways-1:0][line_w-1:0]    load_line_vec;
	logic [nways-1:0]                store_hit_ok_vec, store_hit_inval_vec, store_writing_vec;
	logic [nways-1:0]                fill_write_vec, fill_match_vec;
	logic [moesi_w-1:0]              fill_state;
	logic [nways-1:0][moesi_w-1:0]   fill_state_vec;
	logic [nways-1:0][tag_w-1:0]     fill_tag_vec;
	logic [nways-1:0][line_w-1:0]    fill_line_vec;
	logic [nways-1:0]                snoop_write_vec, snoop_match_vec;
	logic [moesi_w-1:0]              snoop_state;
	logic [nways-1:0][moesi_w-1:0]   snoop_state_vec;
	logic [nways-1:0][line_w-1:0]    snoop_line_vec;

	for (genvar w = 0; w < nways; w++) begin : g_way
		dcache_way way_i (
			.clk(clk), .reset(reset),
			.load_addr(load_addr),
			.store_en(store_en), .store_addr(store_addr),
			.store_data(store_data), .store_mask(store_mask),
			.fill_addr(fill_addr), .fill_data(fill_data),
			.fill_write(fill_write_vec[w]), .fill_state(fill_state),
			.snoop_addr(snoop_addr), .snoop_write(snoop_write_vec[w]),
			.snoop_state(snoop_state),
			.load_match(load_match_vec[w]), .load_need_o(load_need_vec[w]),
			.load_line(load_line_vec[w]),
			.store_hit_ok(store_hit_ok_vec[w]), .store_hit_inval(store_hit_inval_vec[w]),
			.store_writing(store_writing_vec[w]),
			.fill_match(fill_match_vec[w]), .fill_state_now(fill_state_vec[w]),
			.fill_tag_now(fill_tag_vec[w]), .fill_line_now(fill_line_vec[w]),
			.snoop_match(snoop_match_vec[w]), .snoop_state_now(snoop_state_vec[w]),
			.snoop_line(snoop_line_vec[w])
		);
	end

	assign store_ok_write        = |store_hit_ok_vec;
	assign store_must_invalidate = |store_hit_inval_vec;
	assign store_wait            = |(fill_write_vec & store_hit_ok_vec);	// fill owns the way, retry

	load_select load_select_i (
		.load_addr(load_addr), .load_match_vec(load_match_vec),
		.load_need_vec(load_need_vec), .load_line_vec(load_line_vec),
		.load_hit(load_hit), .load_need_o(load_need_o), .load_data(load_data)
	);

	fill_evict_ctrl fill_evict_ctrl_i (
		.clk(clk), .reset(reset),
		.fill_req(fill_req), .fill_addr(fill_addr), .fill_resp(fill_resp),
		.fill_match_vec(fill_match_vec), .fill_state_vec(fill_state_vec),
		.fill_tag_vec(fill_tag_vec), .fill_line_vec(fill_line_vec),
		.store_writing_vec(store_writing_vec), .wb_ack(wb_ack),
		.fill_ack(fill_ack), .fill_write_vec(fill_write_vec), .fill_state(fill_state),
		.wb_req(wb_req), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	snoop_resp snoop_resp_i (
		.clk(clk), .reset(reset),
		.snoop_req(snoop_req), .snoop_type(snoop_type),
		.snoop_match_vec(snoop_match_vec), .snoop_state_vec(snoop_state_vec),
		.snoop_line_vec(snoop_line_vec),
		.snoop_write_vec(snoop_write_vec), .snoop_state(snoop_state),
		.snoop_resp(snoop_resp), .snoop_data(snoop_data)
	);

endmodule

`default_nettype wire

//--- include/tb_tasks.svh
// cache port tasks for the testbench: fill, store, snoop and load with model updates
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	return x;
endfunction

function automatic logic [line_w-1:0] next_line();
	logic [line_w-1:0] l;
	for (int i = 0; i < line_w / 32; i++) begin
		rng = xorshift32(rng);
		l[i*32 +: 32] = rng;
	end
	return l;
endfunction

// placement: refresh, then no-alloc, then lowest vacant way, then rotating victim
task automatic do_fill(input logic [tag_w-1:0] tag, input int idx, input logic [2:0] resp);
	logic [line_w-1:0] line;
	int w;
	line = next_line();
	w = find_way(tag, idx);
	if (w < 0 && resp[0]) begin
		for (int v = nways - 1; v >= 0; v--) begin
			if (m_state[v][idx] == c_i)
				w = v;
		end
		if (w < 0) begin
			w = vptr;
			vptr = (vptr + 1) % nways;
			if (m_state[w][idx] == c_m || m_state[w][idx] == c_o) begin
				exp_wb_addr = {m_tag[w][idx], idx[index_w-1:0], 4'h0};
				exp_wb_data = m_line[w][idx];
			end
		end
	end
	@(negedge clk);
	fill_req = 1'b1;
	fill_addr = {tag, idx[index_w-1:0], 4'h0};
	fill_data = line;
	fill_resp = resp;
	#10;
	while (!fill_ack) begin
		@(negedge clk);
		#10;
	end
	@(negedge clk);
	fill_req = 1'b0;
	if (w >= 0) begin
		m_tag[w][idx] = tag;
		m_line[w][idx] = line;
		m_state[w][idx] = resp[2] ? c_m : (resp[1] ? c_e : c_s);
	end
endtask

task automatic do_store(input logic [addr_w-1:0] addr, input logic [word_w-1:0] data,
		input logic [word_bytes-1:0] mask);
	int w, idx, k;
	logic ok, inval;
	idx = addr[line_off_w +: index_w];
	k = addr[3:2];
	w = find_way(addr[addr_w-1 -: tag_w], idx);
	ok = w >= 0 && (m_state[w][idx] == c_e || m_state[w][idx] == c_m);
	inval = w >= 0 && (m_state[w][idx] == c_s || m_state[w][idx] == c_o);
	@(negedge clk);
	store_en = 1'b1;
	store_addr = addr;
	store_data = data;
	store_mask = mask;
	#10;
	check_value("store_ok_write", ok, store_ok_write);
	check_value("store_must_invalidate", inval, store_must_invalidate);
	check_value("store_wait", 1'b0, store_wait);
	@(negedge clk);
	store_en = 1'b0;
	if (ok) begin
		for (int b = 0; b < word_bytes; b++) begin
			if (mask[b])
				m_line[w][idx][(k*word_bytes + b)*8 +: 8] = data[b*8 +: 8];
		end
		if (m_state[w][idx] == c_e)
			m_state[w][idx] = c_m;	// first store dirties it
	end
endtask

task automatic do_snoop(input logic [tag_w-1:0] tag, input int idx, input logic [1:0] typ,
		input logic [2:0] exp_resp);
	int w;
	w = find_way(tag, idx);
	@(negedge clk);
	snoop_req = 1'b1;
	snoop_addr = {tag, idx[index_w-1:0], 4'h0};
	snoop_type = typ;
	@(negedge clk);
	snoop_req = 1'b0;
	check_value("snoop_resp", exp_resp, snoop_resp);
	if (w >= 0 && typ != snoop_read_invalid)
		check_value("snoop_data", m_line[w][idx], snoop_data);
	if (w >= 0) begin
		if (typ == snoop_read_shared)
			m_state[w][idx] = (m_state[w][idx] == c_m || m_state[w][idx] == c_o) ? c_o : c_s;
		else if (typ != snoop_read_unshared)
			m_state[w][idx] = c_i;
	end
endtask

// every word of the line, hit or miss from the model
task automatic check_load(input logic [tag_w-1:0] tag, input int idx);
	int w;
	w = find_way(tag, idx);
	for (int k = 0; k < line_w / word_w; k++) begin
		@(negedge clk);
		load_addr = {tag, idx[index_w-1:0], k[1:0], 2'b00};
		#10;
		check_value("load_hit", w >= 0, load_hit);
		if (w >= 0) begin
			check_value("load_data", m_line[w][idx][k*word_w +: word_w], load_data);
			check_value("load_need_o", m_state[w][idx] == c_s || m_state[w][idx] == c_o,
				load_need_o);
		end
	end
endtask

`endif

//--- sim/tb_dcache_l1.sv
// testbench for the L1 data cache with fills, loads, stores, snoops, evictions and writebacks
`timescale 1ns/1ps
`default_nettype none

module tb_dcache_l1;
	import dcache_pkg::*;

	localparam int max_cycles = 2000;	// far above the sequence length

	logic                  clk = 1'b0;
	logic                  reset;
	logic [addr_w-1:0]     load_addr, store_addr, fill_addr, snoop_addr, wb_addr;
	logic                  load_hit, load_need_o;
	logic [word_w-1:0]     load_data, store_data;
	logic                  store_en, store_ok_write, store_must_invalidate, store_wait;
	logic [word_bytes-1:0] store_mask;
	logic                  fill_req, fill_ack, wb_req, wb_ack, snoop_req;
	logic [line_w-1:0]     fill_data, wb_data, snoop_data;
	logic [2:0]            fill_resp, snoop_resp;
	logic [1:0]            snoop_type;

	logic [31:0]           rng = 32'he3ae;
	int                    errors = 0;
	int                    checks = 0;
	int                    cycles = 0;
	int                    vptr = 0;	// expected victim pointer
	string                 test_name = "reset";

	// expected contents of the cache
	logic [tag_w-1:0]      m_tag   [nways][nentries];
	logic [moesi_w-1:0]    m_state [nways][nentries];
	logic [line_w-1:0]     m_line  [nways][nentries];
	logic [addr_w-1:0]     exp_wb_addr;
	logic [line_w-1:0]     exp_wb_data;

	dcache_l1 dut_i (.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, errors: %0d of %0d checks", cycles, errors, checks);
			$display("Regression failed");
			$finish;
		end
	end

	wb_hold_check: assert property (@(posedge clk) disable iff (reset)
		wb_req && !wb_ack |=> wb_req && $stable(wb_addr) && $stable(wb_data))
		else begin
			errors++;
			$display("writeback port changed while it waited for wb_ack");
		end

	ack_low_check: assert property (@(posedge clk) disable iff (reset) !fill_ack |-> wb_req)
		else begin
			errors++;
			$display("fill_ack went low with no writeback pending");
		end

	task automatic check_value(input string what, input logic [line_w-1:0] exp,
			input logic [line_w-1:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	function automatic int find_way(input logic [tag_w-1:0] tag, input int idx);
		for (int w = 0; w < nways; w++) begin
			if (m_state[w][idx] != c_i && m_tag[w][idx] == tag)
				return w;
		end
		return -1;
	endfunction

	task automatic check_wb();
		#10;
		check_value("wb_req", 1'b1, wb_req);
		check_value("wb_addr", exp_wb_addr, wb_addr);
		check_value("wb_data", exp_wb_data, wb_data);
	endtask

	task automatic ack_wb();
		@(negedge clk);
		wb_ack = 1'b1;
		@(negedge clk);
		wb_ack = 1'b0;
		#10;
		check_value("wb_req", 1'b0, wb_req);
	endtask

	`include "tb_tasks.svh"

	// refresh fill and store on the same line in one cycle, the store must retry
	task automatic store_into_fill(input logic [tag_w-1:0] tag, input int idx);
		logic [line_w-1:0] line;
		int w;
		line = next_line();
		w = find_way(tag, idx);
		@(negedge clk);
		fill_req = 1'b1;
		fill_addr = {tag, idx[index_w-1:0], 4'h0};
		fill_data = line;
		fill_resp = 3'b011;
		store_en = 1'b1;
		store_addr = {tag, idx[index_w-1:0], 4'h4};
		store_data = ~line[63:32];
		store_mask = 4'b1111;
		#10;
		check_value("fill_ack", 1'b1, fill_ack);
		check_value("store_wait", 1'b1, store_wait);
		@(negedge clk);
		fill_req = 1'b0;
		store_en = 1'b0;
		if (w >= 0) begin
			m_line[w][idx] = line;
			m_state[w][idx] = c_e;
		end
	endtask

	initial begin
		reset = 1'b1;
		load_addr = '0;
		store_en = 1'b0;
		store_addr = '0;
		store_data = '0;
		store_mask = '0;
		fill_req = 1'b0;
		fill_addr = '0;
		fill_data = '0;
		fill_resp = '0;
		wb_ack = 1'b0;
		snoop_req = 1'b0;
		snoop_addr = '0;
		snoop_type = snoop_read_unshared;
		for (int w = 0; w < nways; w++) begin
			for (int i = 0; i < nentries; i++)
				m_state[w][i] = c_i;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("wb_req", 1'b0, wb_req);
		check_value("snoop_resp", 3'b000, snoop_resp);

		test_name = "fill_load";
		do_fill(25'h10, 1, 3'b101);	// M
		do_fill(25'h11, 1, 3'b011);	// E
		do_fill(25'h12, 1, 3'b001);	// S
		check_load(25'h10, 1);
		check_load(25'h11, 1);
		check_load(25'h12, 1);
		check_load(25'h13, 1);

		test_name = "store";
		do_store({25'h11, 3'd1, 4'h8}, 32'hcafe_f00d, 4'b0101);
		check_load(25'h11, 1);
		do_store({25'h12, 3'd1, 4'h4}, 32'h1234_5678, 4'b1111);
		check_load(25'h12, 1);
		do_store({25'h20, 3'd1, 4'h0}, 32'hdead_beef, 4'b1111);

		test_name = "snoop";
		do_fill(25'h13, 1, 3'b011);
		do_snoop(25'h10, 1, snoop_read_shared, 3'b001);
		check_load(25'h10, 1);	// now O
		do_snoop(25'h13, 1, snoop_read_exclusive, 3'b011);
		check_load(25'h13, 1);
		do_snoop(25'h30, 1, snoop_read_unshared, 3'b000);

		test_name = "evict";
		do_fill(25'h40, 3, 3'b101);
		do_fill(25'h41, 3, 3'b101);
		do_fill(25'h42, 3, 3'b011);
		do_fill(25'h43, 3, 3'b001);
		do_fill(25'h44, 3, 3'b011);	// set full so dirty way 0 goes
		check_wb();
		check_load(25'h40, 3);
		check_load(25'h44, 3);

		test_name = "backpressure";
		fork
			do_fill(25'h45, 3, 3'b011);
			begin
				@(negedge clk);
				#10;
				check_value("fill_ack", 1'b0, fill_ack);
				repeat (3) @(negedge clk);
				wb_ack = 1'b1;
				@(negedge clk);
				wb_ack = 1'b0;
			end
		join
		check_wb();	// second victim follows the first
		ack_wb();
		check_load(25'h45, 3);

		test_name = "refresh";
		do_fill(25'h44, 3, 3'b001);
		check_load(25'h44, 3);
		check_load(25'h42, 3);
		check_load(25'h43, 3);
		check_load(25'h45, 3);

		test_name = "store_wait";
		store_into_fill(25'h45, 3);
		check_load(25'h45, 3);

		test_name = "no_alloc";
		do_fill(25'h50, 5, 3'b010);
		check_load(25'h50, 5);

		repeat (2) @(negedge clk);
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
rtl/dcache_pkg.sv
rtl/load_select.sv
rtl/dcache_way.sv
rtl/fill_evict_ctrl.sv
rtl/snoop_resp.sv
rtl/dcache_l1.sv
sim/tb_dcache_l1.sv

//--- Bender.yml
package:
  name: dcache_l1

sources:
  - rtl/dcache_pkg.sv
  - rtl/load_select.sv
  - rtl/dcache_way.sv
  - rtl/fill_evict_ctrl.sv
  - rtl/snoop_resp.sv
  - rtl/dcache_l1.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_dcache_l1.sv
